/* design/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
	input logic clk,
	input logic rst,
	mem_bus_if.slave m0,
	mem_bus_if.slave m1,
	mem_bus_if.master mem
);

	logic busy;
	logic grant;
	logic last;
	logic sel;

	// ------------------------------------------------------------------------
	// owner select
	// ------------------------------------------------------------------------
	always_comb begin
		if (busy) begin
			sel = grant;
		end else if (m0.req_valid && m1.req_valid) begin
			// master not served last goes first
			sel = ~last;
		end else begin
			sel = m1.req_valid;
		end
	end

	// request path, new requests only with no transaction open
	assign mem.req_valid = !busy && (sel ? m1.req_valid : m0.req_valid);
	assign mem.req_addr = sel ? m1.req_addr : m0.req_addr;
	assign mem.req_we = sel ? m1.req_we : m0.req_we;
	assign mem.req_wdata = sel ? m1.req_wdata : m0.req_wdata;
	assign mem.req_wstrb = sel ? m1.req_wstrb : m0.req_wstrb;

	assign m0.req_ready = !busy && !sel && mem.req_ready;
	assign m1.req_ready = !busy && sel && mem.req_ready;

	// response path back to the owner
	assign m0.rsp_valid = busy && !grant && mem.rsp_valid;
	assign m1.rsp_valid = busy && grant && mem.rsp_valid;
	assign m0.rsp_rdata = mem.rsp_rdata;
	assign m1.rsp_rdata = mem.rsp_rdata;
	assign m0.rsp_resp = mem.rsp_resp;
	assign m1.rsp_resp = mem.rsp_resp;
	assign mem.rsp_ready = busy && (grant ? m1.rsp_ready : m0.rsp_ready);

	// ------------------------------------------------------------------------
	// grant tracking
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			grant <= 1'b0;
			last <= 1'b1;
		end else if (!busy) begin
			if (mem.req_valid && mem.req_ready) begin
				busy <= 1'b1;
				grant <= sel;
			end
		end else if (mem.rsp_valid && mem.rsp_ready) begin
			busy <= 1'b0;
			last <= grant;
		end
	end

	// a memory answer always belongs to an open transaction
	a_one_rsp: assert property (@(posedge clk) disable iff (rst)
		mem.rsp_valid |-> busy);

	// memory takes nothing new while the grant is held
	a_grant_held: assert property (@(posedge clk) disable iff (rst)
		busy |-> !mem.req_ready);

endmodule

/* design/mem_bus_if.sv */
`timescale 1ns/1ps

interface mem_bus_if import mmu_pkg::*; ();

	// request channel
	logic req_valid;
	logic req_ready;
	addr_t req_addr;
	logic req_we;
	data_t req_wdata;
	strb_t req_wstrb;

	// response channel
	logic rsp_valid;
	logic rsp_ready;
	data_t rsp_rdata;
	resp_t rsp_resp;

	modport master (
		output req_valid, req_addr, req_we, req_wdata, req_wstrb, rsp_ready,
		input req_ready, rsp_valid, rsp_rdata, rsp_resp
	);

	modport slave (
		input req_valid, req_addr, req_we, req_wdata, req_wstrb, rsp_ready,
		output req_ready, rsp_valid, rsp_rdata, rsp_resp
	);

endinterface

/* design/mmu_pkg.sv */
package mmu_pkg;

	// ------------------------------------------------------------------------
	// field positions
	// ------------------------------------------------------------------------
	localparam int PPN_W = 20;
	localparam int VPN_W = 10;
	localparam int PAGE_OFFSET_BITS = 12;
	localparam int SATP_MODE_BIT = 31;
	localparam int PTE_V_BIT = 0;
	// ppn field starts above the flag bits
	localparam int PTE_PPN_LSB = 10;

	// ------------------------------------------------------------------------
	// bus and translation types
	// ------------------------------------------------------------------------
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0] strb_t;
	typedef logic [PPN_W-1:0] ppn_t;
	typedef logic [VPN_W-1:0] vpn_t;

	// response code carried with every answer
	typedef enum logic [1:0] {
		RESP_OK = 2'd0,
		RESP_PAGE_FAULT = 2'd1,
		RESP_BUS_ERROR = 2'd2
	} resp_t;

endpackage

/* design/mmu_subsystem.sv */
`timescale 1ns/1ps

module mmu_subsystem import mmu_pkg::*; #(
	parameter int MEM_WORDS = 4096
) (
	input logic clk,
	input logic rst,
	input data_t satp,

	// instruction port
	input logic i_req_valid,
	output logic i_req_ready,
	input addr_t i_req_addr,
	input logic i_req_we,
	input data_t i_req_wdata,
	input strb_t i_req_wstrb,
	output logic i_rsp_valid,
	input logic i_rsp_ready,
	output data_t i_rsp_rdata,
	output resp_t i_rsp_resp,

	// data port
	input logic d_req_valid,
	output logic d_req_ready,
	input addr_t d_req_addr,
	input logic d_req_we,
	input data_t d_req_wdata,
	input strb_t d_req_wstrb,
	output logic d_rsp_valid,
	input logic d_rsp_ready,
	output data_t d_rsp_rdata,
	output resp_t d_rsp_resp
);

	mem_bus_if cpu_i_bus ();
	mem_bus_if cpu_d_bus ();
	mem_bus_if mmu_i_bus ();
	mem_bus_if mmu_d_bus ();
	mem_bus_if mem_bus ();

	// ------------------------------------------------------------------------
	// cpu side ports onto the bus bundles
	// ------------------------------------------------------------------------
	assign cpu_i_bus.req_valid = i_req_valid;
	assign cpu_i_bus.req_addr = i_req_addr;
	assign cpu_i_bus.req_we = i_req_we;
	assign cpu_i_bus.req_wdata = i_req_wdata;
	assign cpu_i_bus.req_wstrb = i_req_wstrb;
	assign cpu_i_bus.rsp_ready = i_rsp_ready;
	assign i_req_ready = cpu_i_bus.req_ready;
	assign i_rsp_valid = cpu_i_bus.rsp_valid;
	assign i_rsp_rdata = cpu_i_bus.rsp_rdata;
	assign i_rsp_resp = cpu_i_bus.rsp_resp;

	assign cpu_d_bus.req_valid = d_req_valid;
	assign cpu_d_bus.req_addr = d_req_addr;
	assign cpu_d_bus.req_we = d_req_we;
	assign cpu_d_bus.req_wdata = d_req_wdata;
	assign cpu_d_bus.req_wstrb = d_req_wstrb;
	assign cpu_d_bus.rsp_ready = d_rsp_ready;
	assign d_req_ready = cpu_d_bus.req_ready;
	assign d_rsp_valid = cpu_d_bus.rsp_valid;
	assign d_rsp_rdata = cpu_d_bus.rsp_rdata;
	assign d_rsp_resp = cpu_d_bus.rsp_resp;

	// ------------------------------------------------------------------------
	// translation, arbitration, storage
	// ------------------------------------------------------------------------
	sv32_mmu u_mmu_i (
		.clk (clk),
		.rst (rst),
		.satp (satp),
		.cpu (cpu_i_bus.slave),
		.mem (mmu_i_bus.master)
	);

	sv32_mmu u_mmu_d (
		.clk (clk),
		.rst (rst),
		.satp (satp),
		.cpu (cpu_d_bus.slave),
		.mem (mmu_d_bus.master)
	);

	// instruction side is input 0
	bus_arbiter u_arb (
		.clk (clk),
		.rst (rst),
		.m0 (mmu_i_bus.slave),
		.m1 (mmu_d_bus.slave),
		.mem (mem_bus.master)
	);

	word_memory #(
		.MEM_WORDS (MEM_WORDS)
	) u_mem (
		.clk (clk),
		.rst (rst),
		.bus (mem_bus.slave)
	);

endmodule

/* design/sv32_mmu.sv */
`timescale 1ns/1ps

module sv32_mmu import mmu_pkg::*; (
	input logic clk,
	input logic rst,
	input data_t satp,
	mem_bus_if.slave cpu,
	mem_bus_if.master mem
);

	typedef enum logic [3:0] {
		IDLE,
		PTE1_REQ,
		PTE1_RSP,
		PTE2_REQ,
		PTE2_RSP,
		DATA_REQ,
		DATA_RSP,
		DONE,
		FORWARD
	} mmu_state_t;

	mmu_state_t state;
	ppn_t root_q;
	ppn_t pte_ppn_q;
	data_t rdata_q;
	resp_t resp_q;

	logic fwd;
	vpn_t vpn1;
	vpn_t vpn0;
	logic [PAGE_OFFSET_BITS-1:0] page_off;
	addr_t pte1_addr;
	addr_t pte2_addr;
	addr_t paddr;
	ppn_t rsp_ppn;
	logic pte_valid;
	logic pte_bad;

	// ------------------------------------------------------------------------
	// address formation
	// ------------------------------------------------------------------------
	assign vpn1 = cpu.req_addr[PAGE_OFFSET_BITS + VPN_W +: VPN_W];
	assign vpn0 = cpu.req_addr[PAGE_OFFSET_BITS +: VPN_W];
	assign page_off = cpu.req_addr[PAGE_OFFSET_BITS-1:0];

	assign pte1_addr = {root_q, vpn1, 2'b00};
	assign pte2_addr = {pte_ppn_q, vpn0, 2'b00};
	// upper ppn bits dropped, 32-bit physical space
	assign paddr = {pte_ppn_q, page_off};

	assign rsp_ppn = mem.rsp_rdata[PTE_PPN_LSB +: PPN_W];
	assign pte_valid = mem.rsp_rdata[PTE_V_BIT];
	assign pte_bad = (mem.rsp_resp != RESP_OK) || !pte_valid;

	// bare mode passes straight through, already in idle
	assign fwd = (state == FORWARD) || (state == IDLE && !satp[SATP_MODE_BIT]);

	// ------------------------------------------------------------------------
	// channel steering
	// ------------------------------------------------------------------------
	always_comb begin
		mem.req_valid = 1'b0;
		mem.req_addr = pte1_addr;
		mem.req_we = 1'b0;
		mem.req_wdata = cpu.req_wdata;
		mem.req_wstrb = cpu.req_wstrb;
		mem.rsp_ready = 1'b0;
		cpu.req_ready = 1'b0;
		cpu.rsp_valid = 1'b0;
		cpu.rsp_rdata = rdata_q;
		cpu.rsp_resp = resp_q;
		if (fwd) begin
			mem.req_valid = cpu.req_valid;
			mem.req_addr = cpu.req_addr;
			mem.req_we = cpu.req_we;
			mem.rsp_ready = cpu.rsp_ready;
			cpu.req_ready = mem.req_ready;
			cpu.rsp_valid = mem.rsp_valid;
			cpu.rsp_rdata = mem.rsp_rdata;
			cpu.rsp_resp = mem.rsp_resp;
		end else begin
			case (state)
				PTE1_REQ: begin
					mem.req_valid = 1'b1;
				end
				PTE2_REQ: begin
					mem.req_valid = 1'b1;
					mem.req_addr = pte2_addr;
				end
				DATA_REQ: begin
					mem.req_valid = 1'b1;
					mem.req_addr = paddr;
					mem.req_we = cpu.req_we;
				end
				PTE1_RSP, PTE2_RSP, DATA_RSP: begin
					mem.rsp_ready = 1'b1;
				end
				DONE: begin
					cpu.req_ready = 1'b1;
					cpu.rsp_valid = 1'b1;
				end
				default: begin
				end
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// walk state machine
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (cpu.req_valid) begin
						state <= satp[SATP_MODE_BIT] ? PTE1_REQ : FORWARD;
					end
				end
				FORWARD: begin
					if (mem.rsp_valid && cpu.rsp_ready) begin
						state <= IDLE;
					end
				end
				PTE1_REQ: begin
					if (mem.req_ready) begin
						state <= PTE1_RSP;
					end
				end
				PTE1_RSP: begin
					if (mem.rsp_valid) begin
						state <= pte_bad ? DONE : PTE2_REQ;
					end
				end
				PTE2_REQ: begin
					if (mem.req_ready) begin
						state <= PTE2_RSP;
					end
				end
				PTE2_RSP: begin
					if (mem.rsp_valid) begin
						state <= pte_bad ? DONE : DATA_REQ;
					end
				end
				DATA_REQ: begin
					if (mem.req_ready) begin
						state <= DATA_RSP;
					end
				end
				DATA_RSP: begin
					if (mem.rsp_valid) begin
						state <= DONE;
					end
				end
				DONE: begin
					if (cpu.rsp_ready) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// root, pte and answer registers
	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				root_q <= satp[PPN_W-1:0];
			end
			PTE1_RSP, PTE2_RSP: begin
				if (mem.rsp_valid) begin
					pte_ppn_q <= rsp_ppn;
					rdata_q <= '0;
					// a bus error wins over the fault
					resp_q <= (mem.rsp_resp != RESP_OK) ? mem.rsp_resp : RESP_PAGE_FAULT;
				end
			end
			DATA_RSP: begin
				if (mem.rsp_valid) begin
					rdata_q <= mem.rsp_rdata;
					resp_q <= mem.rsp_resp;
				end
			end
			default: begin
			end
		endcase
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	a_req_addr_stable: assert property (@(posedge clk) disable iff (rst)
		cpu.req_valid && !cpu.req_ready |=> $stable(cpu.req_addr));

	a_rsp_state: assert property (@(posedge clk) disable iff (rst)
		cpu.rsp_valid |-> (state == DONE || state == FORWARD));

endmodule

/* design/word_memory.sv */
`timescale 1ns/1ps

module word_memory import mmu_pkg::*; #(
	parameter int MEM_WORDS = 4096
) (
	input logic clk,
	input logic rst,
	mem_bus_if.slave bus
);

	localparam int IDX_W = $clog2(MEM_WORDS);

	data_t mem [MEM_WORDS];
	logic pending;
	data_t rdata_q;
	resp_t resp_q;

	logic [29:0] word_idx;
	logic [IDX_W-1:0] idx;
	logic in_range;
	logic accept;

	assign word_idx = bus.req_addr[31:2];
	assign idx = word_idx[IDX_W-1:0];
	assign in_range = {2'b00, word_idx} < MEM_WORDS;
	assign accept = bus.req_valid && bus.req_ready;

	// one request at a time
	assign bus.req_ready = !pending;
	assign bus.rsp_valid = pending;
	assign bus.rsp_rdata = rdata_q;
	assign bus.rsp_resp = resp_q;

	// ------------------------------------------------------------------------
	// array and pending flag
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= 1'b0;
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (accept) begin
			pending <= 1'b1;
			if (in_range && bus.req_we) begin
				for (int b = 0; b < 4; b++) begin
					if (bus.req_wstrb[b]) begin
						mem[idx][8*b +: 8] <= bus.req_wdata[8*b +: 8];
					end
				end
			end
		end else if (bus.rsp_valid && bus.rsp_ready) begin
			pending <= 1'b0;
		end
	end

	// registered answer, zero data on writes and out of range
	always_ff @(posedge clk) begin
		if (accept) begin
			rdata_q <= (in_range && !bus.req_we) ? mem[idx] : '0;
			resp_q <= in_range ? RESP_OK : RESP_BUS_ERROR;
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# build the testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_mmu_subsystem -f src.f -o tb_sim &&
	./obj_dir/tb_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
	echo "simulation run ok" &&
	exit 0
echo "simulation run not ok"
exit 1

/* sim/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int PERIOD_NS = 8,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk = ~clk;
		end
	end

	// released on a falling edge, like all other stimulus
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

/* sim/tb_mmu_subsystem.sv */
`timescale 1ns/1ps

module tb_mmu_subsystem import mmu_pkg::*; ();

	localparam int MEM_WORDS = 8192;
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int SETTLE_NS = 1;
	localparam bit I_PORT = 1'b0;
	localparam bit D_PORT = 1'b1;

	localparam data_t SATP_BARE = 32'h0000_0000;
	// mode set, root table in page 1
	localparam data_t SATP_SV32 = 32'h8000_0001;
	localparam ppn_t ROOT_PPN = 20'd1;
	localparam ppn_t L2_PPN = 20'd2;
	localparam ppn_t PPN_A = 20'd3;
	localparam ppn_t PPN_B = 20'd4;
	localparam ppn_t PPN_C = 20'd5;
	localparam ppn_t PPN_D = 20'd6;

	// vpn1 1 for a, b, c and vpn1 2 for d
	localparam addr_t VA_A = 32'h0040_3000;
	localparam addr_t VA_B = 32'h0040_4000;
	localparam addr_t VA_C = 32'h0040_5000;
	localparam addr_t VA_D = 32'h0080_6000;

	logic clk;
	logic rst;
	data_t satp;
	logic [1:0] req_valid;
	addr_t req_addr [2];
	logic [1:0] req_we;
	data_t req_wdata [2];
	strb_t req_wstrb [2];
	logic [1:0] rsp_ready;

	logic i_req_ready;
	logic i_rsp_valid;
	data_t i_rsp_rdata;
	resp_t i_rsp_resp;
	logic d_req_ready;
	logic d_rsp_valid;
	data_t d_rsp_rdata;
	resp_t d_rsp_resp;

	data_t ref_mem [MEM_WORDS];
	int seed = 32'hd712;
	int error_count = 0;
	int cycle_count = 0;

	tb_clkgen #(
		.PERIOD_NS (8),
		.RESET_CYCLES (4)
	) u_clkgen (
		.clk (clk),
		.rst (rst)
	);

	mmu_subsystem #(
		.MEM_WORDS (MEM_WORDS)
	) u_dut (
		.clk (clk),
		.rst (rst),
		.satp (satp),
		.i_req_valid (req_valid[0]),
		.i_req_ready (i_req_ready),
		.i_req_addr (req_addr[0]),
		.i_req_we (req_we[0]),
		.i_req_wdata (req_wdata[0]),
		.i_req_wstrb (req_wstrb[0]),
		.i_rsp_valid (i_rsp_valid),
		.i_rsp_ready (rsp_ready[0]),
		.i_rsp_rdata (i_rsp_rdata),
		.i_rsp_resp (i_rsp_resp),
		.d_req_valid (req_valid[1]),
		.d_req_ready (d_req_ready),
		.d_req_addr (req_addr[1]),
		.d_req_we (req_we[1]),
		.d_req_wdata (req_wdata[1]),
		.d_req_wstrb (req_wstrb[1]),
		.d_rsp_valid (d_rsp_valid),
		.d_rsp_ready (rsp_ready[1]),
		.d_rsp_rdata (d_rsp_rdata),
		.d_rsp_resp (d_rsp_resp)
	);

	// ------------------------------------------------------------------------
	// reporting and reference model
	// ------------------------------------------------------------------------
	task automatic stop_run();
		error_count++;
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond === 1'b1) else begin
			$display("error: %s", what);
			stop_run();
		end
	endtask

	function automatic string port_name(input bit port);
		return port ? "d" : "i";
	endfunction

	function automatic addr_t entry_addr(input ppn_t table_ppn, input vpn_t vpn);
		return {table_ppn, vpn, 2'b00};
	endfunction

	function automatic data_t make_pte(input ppn_t ppn, input logic valid);
		return {2'b00, ppn, 9'd0, valid};
	endfunction

	function automatic addr_t leaf_addr(input ppn_t ppn, input addr_t va);
		return {ppn, va[11:0]};
	endfunction

	function automatic void ref_write(input addr_t addr, input data_t data,
			input strb_t strb);
		int unsigned w;
		w = addr >> 2;
		if (w < MEM_WORDS) begin
			for (int b = 0; b < 4; b++) begin
				if (strb[b]) begin
					ref_mem[w][8*b +: 8] = data[8*b +: 8];
				end
			end
		end
	endfunction

	function automatic data_t ref_read(input addr_t addr);
		int unsigned w;
		w = addr >> 2;
		return (w < MEM_WORDS) ? ref_mem[w] : 32'h0;
	endfunction

	// ------------------------------------------------------------------------
	// port transaction
	// ------------------------------------------------------------------------
	task automatic access(input bit port, input addr_t addr, input logic we,
			input data_t wdata, input strb_t strb, input int hold,
			output data_t rdata, output resp_t resp);
		logic req_open;
		logic req_fire;
		logic rsp_seen;
		logic rsp_fire;
		logic rdy;
		logic vld;
		data_t cur_rdata;
		resp_t cur_resp;
		int stalled;
		req_open = 1'b1;
		rsp_seen = 1'b0;
		rsp_fire = 1'b0;
		stalled = 0;
		rdata = '0;
		resp = RESP_OK;
		@(negedge clk);
		req_valid[port] = 1'b1;
		req_addr[port] = addr;
		req_we[port] = we;
		req_wdata[port] = wdata;
		req_wstrb[port] = strb;
		rsp_ready[port] = (hold == 0);
		while (!rsp_fire) begin
			// sample well before the next rising edge
			#(SETTLE_NS);
			rdy = port ? d_req_ready : i_req_ready;
			vld = port ? d_rsp_valid : i_rsp_valid;
			cur_rdata = port ? d_rsp_rdata : i_rsp_rdata;
			cur_resp = port ? d_rsp_resp : i_rsp_resp;
			if (vld && !rsp_seen) begin
				check_true(!req_open || rdy, "response came before the request was taken");
				rsp_seen = 1'b1;
				rdata = cur_rdata;
				resp = cur_resp;
			end else if (rsp_seen) begin
				check_true(vld, "response dropped while rsp_ready was low");
				check_value({port_name(port), "_rsp_rdata"}, cur_rdata, rdata);
				check_value({port_name(port), "_rsp_resp"}, 32'(cur_resp), 32'(resp));
			end
			req_fire = req_open && rdy;
			rsp_fire = vld && rsp_ready[port];
			@(negedge clk);
			if (req_fire) begin
				req_open = 1'b0;
				req_valid[port] = 1'b0;
			end
			if (rsp_fire) begin
				rsp_ready[port] = 1'b0;
			end else if (rsp_seen) begin
				stalled++;
				if (stalled >= hold) begin
					rsp_ready[port] = 1'b1;
				end
			end
		end
	endtask

	// paddr is where the write lands when it succeeds
	task automatic bus_write(input bit port, input addr_t addr, input addr_t paddr,
			input data_t data, input strb_t strb, input resp_t exp_resp);
		data_t rdata;
		resp_t resp;
		access(port, addr, 1'b1, data, strb, 0, rdata, resp);
		check_value({port_name(port), "_rsp_resp"}, 32'(resp), 32'(exp_resp));
		if (exp_resp == RESP_OK) begin
			ref_write(paddr, data, strb);
		end
	endtask

	task automatic bus_read(input bit port, input addr_t addr, input data_t exp_data,
			input resp_t exp_resp, input int hold);
		data_t rdata;
		resp_t resp;
		access(port, addr, 1'b0, 32'h0, 4'h0, hold, rdata, resp);
		check_value({port_name(port), "_rsp_resp"}, 32'(resp), 32'(exp_resp));
		if (exp_resp != RESP_PAGE_FAULT) begin
			check_value({port_name(port), "_rsp_rdata"}, rdata, exp_data);
		end
	endtask

	task automatic set_satp(input data_t value);
		@(negedge clk);
		satp = value;
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------
	task automatic test_bare_rw();
		data_t data;
		set_satp(SATP_BARE);
		for (int k = 0; k < 16; k++) begin
			data = $random(seed);
			bus_write(D_PORT, k * 4, k * 4, data, 4'hf, RESP_OK);
		end
		for (int k = 0; k < 16; k++) begin
			bus_read(I_PORT, k * 4, ref_read(k * 4), RESP_OK, 0);
		end
		// byte lanes 0 and 2 only
		bus_write(D_PORT, 32'h0000_000C, 32'h0000_000C, 32'hA5C3_5A3C, 4'b0101, RESP_OK);
		bus_read(I_PORT, 32'h0000_000C, ref_read(32'h0000_000C), RESP_OK, 2);
	endtask

	task automatic test_bus_error();
		bus_read(I_PORT, MEM_WORDS * 4, 32'h0, RESP_BUS_ERROR, 0);
		bus_write(D_PORT, MEM_WORDS * 4 + 8, MEM_WORDS * 4 + 8, 32'hDEAD_BEEF, 4'hf,
			RESP_BUS_ERROR);
		// word 2 shares the low index bits with the rejected write
		bus_read(I_PORT, 32'h0000_0008, ref_read(32'h0000_0008), RESP_OK, 0);
		bus_read(D_PORT, 32'h0000_0000, ref_read(32'h0000_0000), RESP_OK, 0);
	endtask

	task automatic build_tables();
		addr_t a;
		a = entry_addr(ROOT_PPN, 10'd1);
		bus_write(D_PORT, a, a, make_pte(L2_PPN, 1'b1), 4'hf, RESP_OK);
		// points at a good table but is not valid
		a = entry_addr(ROOT_PPN, 10'd2);
		bus_write(D_PORT, a, a, make_pte(L2_PPN, 1'b0), 4'hf, RESP_OK);
		a = entry_addr(L2_PPN, 10'd3);
		bus_write(D_PORT, a, a, make_pte(PPN_A, 1'b1), 4'hf, RESP_OK);
		a = entry_addr(L2_PPN, 10'd4);
		bus_write(D_PORT, a, a, make_pte(PPN_B, 1'b1), 4'hf, RESP_OK);
		a = entry_addr(L2_PPN, 10'd5);
		bus_write(D_PORT, a, a, make_pte(PPN_C, 1'b0), 4'hf, RESP_OK);
		a = entry_addr(L2_PPN, 10'd6);
		bus_write(D_PORT, a, a, make_pte(PPN_D, 1'b1), 4'hf, RESP_OK);
	endtask

	task automatic test_translate();
		data_t data;
		addr_t va;
		set_satp(SATP_BARE);
		build_tables();
		set_satp(SATP_SV32);
		va = VA_A + 32'h24;
		data = $random(seed);
		bus_write(D_PORT, va, leaf_addr(PPN_A, va), data, 4'hf, RESP_OK);
		bus_read(D_PORT, va, data, RESP_OK, 0);
		bus_read(I_PORT, va, data, RESP_OK, 1);
		set_satp(SATP_BARE);
		bus_read(I_PORT, leaf_addr(PPN_A, va), data, RESP_OK, 0);
	endtask

	task automatic test_page_fault();
		set_satp(SATP_SV32);
		bus_write(D_PORT, VA_C, leaf_addr(PPN_C, VA_C), 32'h1234_5678, 4'hf,
			RESP_PAGE_FAULT);
		bus_write(I_PORT, VA_D, leaf_addr(PPN_D, VA_D), 32'h8765_4321, 4'hf,
			RESP_PAGE_FAULT);
		bus_read(D_PORT, VA_C + 32'h4, 32'h0, RESP_PAGE_FAULT, 0);
		bus_read(I_PORT, VA_D, 32'h0, RESP_PAGE_FAULT, 0);
		set_satp(SATP_BARE);
		// both target pages still hold their reset value
		bus_read(I_PORT, leaf_addr(PPN_C, VA_C), 32'h0, RESP_OK, 0);
		bus_read(D_PORT, leaf_addr(PPN_D, VA_D), 32'h0, RESP_OK, 0);
	endtask

	task automatic test_concurrent();
		data_t data_a;
		data_t data_b;
		addr_t va_a;
		addr_t va_b;
		va_a = VA_A + 32'h100;
		va_b = VA_B + 32'h200;
		data_a = $random(seed);
		data_b = $random(seed);
		set_satp(SATP_BARE);
		bus_write(D_PORT, leaf_addr(PPN_A, va_a), leaf_addr(PPN_A, va_a), data_a, 4'hf,
			RESP_OK);
		bus_write(I_PORT, leaf_addr(PPN_B, va_b), leaf_addr(PPN_B, va_b), data_b, 4'hf,
			RESP_OK);
		set_satp(SATP_SV32);
		fork
			bus_read(I_PORT, va_a, data_a, RESP_OK, 5);
			bus_read(D_PORT, va_b, data_b, RESP_OK, 3);
		join
		set_satp(SATP_BARE);
	endtask

	// ------------------------------------------------------------------------
	// run control
	// ------------------------------------------------------------------------
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("error: timeout, tests still running after %0d cycles",
				TIMEOUT_CYCLES);
			stop_run();
		end
	end

	initial begin
		satp = SATP_BARE;
		req_valid = '0;
		req_we = '0;
		rsp_ready = '0;
		for (int p = 0; p < 2; p++) begin
			req_addr[p] = '0;
			req_wdata[p] = '0;
			req_wstrb[p] = '0;
		end
		// memory comes out of reset cleared
		for (int w = 0; w < MEM_WORDS; w++) begin
			ref_mem[w] = '0;
		end
		@(negedge rst);
		test_bare_rw();
		test_bus_error();
		test_translate();
		test_page_fault();
		test_concurrent();
		if (error_count == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("TESTBENCH FAILED");
			$fatal(1, "checks reported errors");
		end
	end

endmodule

/* src.f */
design/mmu_pkg.sv
design/mem_bus_if.sv
design/sv32_mmu.sv
design/bus_arbiter.sv
design/word_memory.sv
design/mmu_subsystem.sv
sim/tb_clkgen.sv
sim/tb_mmu_subsystem.sv
